/* design/counter_pkg.sv */
`default_nettype none

package counter_pkg;

    typedef logic [3:0] bcd_t;                      // One decimal digit, 0 to 9

    typedef struct packed {
        bcd_t tens;                                 // Upper nibble, drives LEDs 7..4
        bcd_t units;                                // Lower nibble, drives LEDs 3..0
    } bcd_pair_t;

    typedef struct packed {
        logic [6:0] seg;                            // Active low, seg[0] is a, seg[6] is g
        logic [7:0] an;                             // Active low digit enables
    } display_t;

    localparam logic [6:0] SEG_OFF = 7'b111_1111;  // All segments dark
    localparam logic [7:0] AN_OFF  = 8'hFF;        // No digit enabled

    // Active-low pattern, bit order g f e d c b a
    function automatic logic [6:0] seg_decode(input bcd_t digit);
        case (digit)
            4'd0:    seg_decode = 7'b100_0000;
            4'd1:    seg_decode = 7'b111_1001;
            4'd2:    seg_decode = 7'b010_0100;
            4'd3:    seg_decode = 7'b011_0000;
            4'd4:    seg_decode = 7'b001_1001;
            4'd5:    seg_decode = 7'b001_0010;
            4'd6:    seg_decode = 7'b000_0010;
            4'd7:    seg_decode = 7'b111_1000;
            4'd8:    seg_decode = 7'b000_0000;
            4'd9:    seg_decode = 7'b001_0000;
            default: seg_decode = SEG_OFF;          // Non-BCD codes stay blank
        endcase
    endfunction

endpackage

`default_nettype wire

/* design/tick_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tick_gen #(
    parameter int DIV_WIDTH = 32                    // Width of the free-running divider
) (
    input  wire logic       clk,                    // System clock
    input  wire logic       rst_n,                  // Async reset, active low
    input  wire logic [4:0] sw,                     // Picks divider bit, higher is slower
    output logic            tick                    // One-cycle count strobe
);

    logic [DIV_WIDTH-1:0] div_cnt;                  // Free-running divider
    logic                 sel_bit;                  // Divider bit chosen by sw
    logic                 sel_d;                    // Selected bit one cycle ago
    logic                 sel_rise;                 // Rising edge of selected bit

    // Divider counts every cycle from zero
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;              // Wraps naturally
        end
    end

    // Bits beyond the divider read as zero, no strobe then
    always_comb begin
        if (int'(sw) < DIV_WIDTH) begin
            sel_bit = div_cnt[sw];
        end else begin
            sel_bit = 1'b0;
        end
    end

    // Delay of the selected bit for edge detection
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sel_d <= 1'b0;
        end else begin
            sel_d <= sel_bit;                       // A sw change may fake one edge
        end
    end

    assign sel_rise = sel_bit & ~sel_d;             // High the cycle after the 0-to-1 edge

    // Registered strobe, one cycle behind the edge detect
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tick <= 1'b0;
        end else begin
            tick <= sel_rise;                       // Period is 2**(sw+1) cycles
        end
    end

endmodule

`default_nettype wire

/* design/bcd_digit.sv */
`timescale 1ns/1ps
`default_nettype none

module bcd_digit
    import counter_pkg::*;
(
    input  wire logic clk,                          // System clock
    input  wire logic rst_n,                        // Async reset, active low
    input  wire logic tick,                         // Count strobe from the divider
    input  wire logic en,                           // Step enable, carry of lower digit
    input  wire logic dir,                          // 1 counts down, 0 counts up
    output bcd_t      value,                        // Current digit
    output logic      carry                         // Rollover on this strobe
);

    logic step;                                     // Digit moves at next edge
    logic at_limit;                                 // Digit sits at its wrap point
    bcd_t value_next;                               // Next digit value

    assign step = tick & en;

    // Wrap point is 9 counting up and 0 counting down
    assign at_limit = dir ? (value == 4'd0) : (value == 4'd9);

    // Combinational so the next digit steps on the same edge
    assign carry = step & at_limit;

    always_comb begin
        if (dir) begin
            if (at_limit) begin
                value_next = 4'd9;                  // 0 wraps to 9
            end else begin
                value_next = value - 4'd1;
            end
        end else begin
            if (at_limit) begin
                value_next = 4'd0;                  // 9 wraps to 0
            end else begin
                value_next = value + 4'd1;
            end
        end
    end

    // Digit register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            value <= 4'd0;
        end else if (step) begin
            value <= value_next;                    // One step per enabled strobe
        end
    end

endmodule

`default_nettype wire

/* design/seg_scan.sv */
`timescale 1ns/1ps
`default_nettype none

module seg_scan
    import counter_pkg::*;
#(
    parameter int SCAN_BITS = 4                     // log2 of digit dwell time in cycles
) (
    input  wire logic      clk,                     // System clock
    input  wire logic      rst_n,                   // Async reset, active low
    input  wire bcd_pair_t digits,                  // Tens and units to show
    output display_t       display                  // Segments and anodes, active low
);

    logic [SCAN_BITS:0] scan_cnt;                   // Dwell counter, top bit is phase
    logic               show_tens;                  // Current phase selects tens
    bcd_t               digit_sel;                  // Digit for current phase
    logic [7:0]         an_next;                    // Anode pattern for current phase
    display_t           display_next;               // Decoded output before the register
    display_t           display_q;                  // Registered output

    // Scan counter runs every cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            scan_cnt <= '0;
        end else begin
            scan_cnt <= scan_cnt + 1'b1;
        end
    end

    assign show_tens = scan_cnt[SCAN_BITS];         // Half the scan period per digit

    // Phase picks digit and its anode
    always_comb begin
        an_next = AN_OFF;                           // Upper six digits stay dark
        if (show_tens) begin
            digit_sel  = digits.tens;
            an_next[1] = 1'b0;                      // Second digit from the right
        end else begin
            digit_sel  = digits.units;
            an_next[0] = 1'b0;                      // Rightmost digit
        end
    end

    // Segments and anode leave the same register
    always_comb begin
        display_next.seg = seg_decode(digit_sel);
        display_next.an  = an_next;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            display_q.seg <= SEG_OFF;               // Blank until first scan cycle
            display_q.an  <= AN_OFF;
        end else begin
            display_q <= display_next;              // One cycle behind the pair
        end
    end

    assign display = display_q;

endmodule

`default_nettype wire

/* design/bcd_display_top.sv */
`timescale 1ns/1ps
`default_nettype none

module bcd_display_top
    import counter_pkg::*;
#(
    parameter int DIV_WIDTH = 32,                   // Divider width for the count strobe
    parameter int SCAN_BITS = 4                     // Digit dwell exponent for the scanner
) (
    input  wire logic       clk,                    // System clock
    input  wire logic       rst_n,                  // Async reset, active low
    input  wire logic       dir,                    // 1 counts down, 0 counts up
    input  wire logic [4:0] sw,                     // Count speed select
    output display_t        display,                // Seven-segment segments and anodes
    output logic      [4:0] sw_led,                 // Switch mirror
    output bcd_pair_t       bcd_led                 // Counter value on LEDs
);

    logic      tick;                                // Count strobe
    bcd_t      units_val;                           // Units digit
    bcd_t      tens_val;                            // Tens digit
    logic      units_carry;                         // Units rollover steps the tens digit
    bcd_pair_t digits;                              // Both digits packed together

    tick_gen #(
        .DIV_WIDTH (DIV_WIDTH)
    ) tick_gen_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .sw    (sw),
        .tick  (tick)
    );

    bcd_digit units_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .tick  (tick),
        .en    (1'b1),                              // Units step on every strobe
        .dir   (dir),
        .value (units_val),
        .carry (units_carry)
    );

    bcd_digit tens_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .tick  (tick),
        .en    (units_carry),                       // Tens follow units rollover
        .dir   (dir),
        .value (tens_val),
        .carry ()                                   // No hundreds digit to feed
    );

    assign digits.tens  = tens_val;
    assign digits.units = units_val;

    seg_scan #(
        .SCAN_BITS (SCAN_BITS)
    ) scan_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .digits  (digits),
        .display (display)
    );

    assign bcd_led = digits;                        // Tens on LEDs 7..4, units on 3..0
    assign sw_led  = sw;                            // Plain copy of the switches

endmodule

`default_nettype wire

/* dv/tb_bcd_display.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_bcd_display
    import counter_pkg::*;
();

    localparam int SCAN_BITS    = 4;                    // Short dwell for simulation
    localparam int SCAN_WINDOW  = 2 ** (SCAN_BITS + 1); // Both anodes show within this
    localparam int MAX_TESTS    = 64;
    localparam int RESET_CYCLES = 3;

    logic       clk = 1'b0;
    logic       rst_n;
    logic       dir;                                    // 1 counts down
    logic [4:0] sw;
    display_t   display;
    logic [4:0] sw_led;
    bcd_pair_t  bcd_led;

    logic [7:0]  pattern_mem [0:4*MAX_TESTS-1];         // Four bytes per test
    int          num_tests;
    int          timeout_limit = 0;                     // Cycles, set after file load
    int          cycle_count = 0;
    int          errors;
    int          pass_count;
    int          fail_count;
    logic [31:0] rng_state;
    int          sample_wait;                           // Cycles to next segment sample
    int          units_gap;                             // Cycles since units anode seen
    int          tens_gap;
    int          changes_since_sw;                      // Strobes since last tap change
    int          last_change_cycle;
    bcd_pair_t   prev_pair;                             // bcd_led one cycle earlier

    bcd_display_top #(
        .DIV_WIDTH (32),
        .SCAN_BITS (SCAN_BITS)
    ) bcd_display_top_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .dir     (dir),
        .sw      (sw),
        .display (display),
        .sw_led  (sw_led),
        .bcd_led (bcd_led)
    );

    always #50 clk = ~clk;                              // 100 ns period

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (timeout_limit > 0 && cycle_count > timeout_limit) begin
            $display("Run stopped after %0d cycles with patterns still running", cycle_count);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Decimal value 00..99 moved by one, wrapping both ways
    function automatic bcd_pair_t next_pair(input bcd_pair_t p, input logic down);
        int        n;
        bcd_pair_t r;
        n = int'(p.tens) * 10 + int'(p.units);
        if (down) begin
            n = (n + 99) % 100;
        end else begin
            n = (n + 1) % 100;
        end
        r.tens  = 4'(n / 10);
        r.units = 4'(n % 10);
        return r;
    endfunction

    // Lit segments per digit on a standard display, then inverted for active low
    function automatic logic [6:0] segments_for(input bcd_t d);
        logic [6:0] lit;                                // Bit 0 is segment a
        lit[0] = !(d inside {4'd1, 4'd4});
        lit[1] = !(d inside {4'd5, 4'd6});
        lit[2] = (d != 4'd2);
        lit[3] = !(d inside {4'd1, 4'd4, 4'd7});
        lit[4] = d inside {4'd0, 4'd2, 4'd6, 4'd8};
        lit[5] = !(d inside {4'd1, 4'd2, 4'd3, 4'd7});
        lit[6] = !(d inside {4'd0, 4'd1, 4'd7});
        if (d > 4'd9) begin
            lit = '0;                                   // Blank for non-BCD
        end
        return ~lit;
    endfunction

    task automatic check_pair(input string name, input bcd_pair_t exp, input bcd_pair_t act);
        if (act !== exp) begin
            errors++;
            $display("Error at %0t: %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_display(input display_t exp, input display_t act);
        if (act !== exp) begin
            errors++;
            $display("Error at %0t: display expected seg %b an %b got seg %b an %b",
                     $time, exp.seg, exp.an, act.seg, act.an);
        end
    endtask

    task automatic check_mirror(input logic [4:0] exp, input logic [4:0] act);
        if (act !== exp) begin
            errors++;
            $display("Error at %0t: sw_led expected %b got %b", $time, exp, act);
        end
    endtask

    task automatic check_interval(input string name, input int exp, input int act);
        if (act != exp) begin
            errors++;
            $display("Error at %0t: %s expected %0d cycles got %0d", $time, name, exp, act);
        end
    endtask

    // One cycle of monitoring at the falling edge, where outputs are settled
    task automatic watch_cycle(input logic down, input int period, output logic changed);
        bcd_pair_t cur;
        display_t  exp_disp;
        @(negedge clk);
        cur       = bcd_led;
        changed   = 1'b0;
        units_gap = (display.an == 8'b1111_1110) ? 0 : units_gap + 1;
        tens_gap  = (display.an == 8'b1111_1101) ? 0 : tens_gap + 1;
        if (units_gap > SCAN_WINDOW) begin
            errors++;
            $display("Units digit not scanned within %0d cycles at %0t", SCAN_WINDOW, $time);
            units_gap = 0;
        end
        if (tens_gap > SCAN_WINDOW) begin
            errors++;
            $display("Tens digit not scanned within %0d cycles at %0t", SCAN_WINDOW, $time);
            tens_gap = 0;
        end
        if (sample_wait == 0) begin
            rng_state   = xorshift32(rng_state);
            sample_wait = int'(rng_state[2:0]);         // 0 to 7 idle cycles
            if (display.an == 8'b1111_1110) begin
                exp_disp.an  = 8'b1111_1110;
                exp_disp.seg = segments_for(prev_pair.units);
                check_display(exp_disp, display);
            end else if (display.an == 8'b1111_1101) begin
                exp_disp.an  = 8'b1111_1101;
                exp_disp.seg = segments_for(prev_pair.tens);
                check_display(exp_disp, display);
            end else begin
                errors++;
                $display("Display at %0t enables neither the units nor the tens digit", $time);
            end
        end else begin
            sample_wait--;
        end
        if (cur !== prev_pair) begin
            changed = 1'b1;
            check_pair("bcd_led step", next_pair(prev_pair, down), cur);
            // A moved tap can fake one edge, so the first full interval is loose
            if (changes_since_sw >= 2) begin
                check_interval("bcd_led interval", period, cycle_count - last_change_cycle);
            end
            changes_since_sw++;
            last_change_cycle = cycle_count;
        end
        prev_pair = cur;
    endtask

    task automatic run_line(input int t);
        logic       line_dir;
        logic [4:0] line_sw;
        int         steps;
        bcd_pair_t  expected;
        int         period;
        int         steps_done;
        int         err_before;
        logic       changed;
        line_dir   = pattern_mem[4*t][0];
        line_sw    = pattern_mem[4*t+1][4:0];
        steps      = int'(pattern_mem[4*t+2]);
        expected   = bcd_pair_t'(pattern_mem[4*t+3]);
        period     = 1 << (int'(line_sw) + 1);          // Strobe spacing for this tap
        err_before = errors;
        steps_done = 0;
        @(posedge clk);
        #1;
        if (line_sw != sw) begin
            changes_since_sw = 0;
        end
        dir = line_dir;
        sw  = line_sw;
        while (steps_done < steps) begin
            watch_cycle(line_dir, period, changed);
            if (changed) begin
                steps_done++;
            end
        end
        check_pair("bcd_led", expected, bcd_led);
        check_mirror(line_sw, sw_led);
        if (errors == err_before) begin
            pass_count++;
            $display("Test %0d dir %0d sw %0d steps %0d end %h: pass",
                     t + 1, line_dir, line_sw, steps, bcd_led);
        end else begin
            fail_count++;
            $display("Test %0d dir %0d sw %0d steps %0d end %h: fail",
                     t + 1, line_dir, line_sw, steps, bcd_led);
        end
    endtask

    initial begin
        display_t dark;
        int       err_before;
        dark.seg          = 7'b111_1111;
        dark.an           = 8'b1111_1111;
        rst_n             = 1'b0;
        dir               = 1'b0;
        sw                = 5'd0;
        errors            = 0;
        pass_count        = 0;
        fail_count        = 0;
        num_tests         = 0;
        rng_state         = 32'd48;
        sample_wait       = 0;
        units_gap         = 0;
        tens_gap          = 0;
        changes_since_sw  = 0;
        last_change_cycle = 0;
        prev_pair         = '0;

        $readmemh("dv/count_patterns.txt", pattern_mem);
        // Budget grows with each line's strobe count and spacing
        while (num_tests < MAX_TESTS && pattern_mem[4*num_tests] != 8'hFF) begin
            timeout_limit += int'(pattern_mem[4*num_tests+2])
                             * (1 << (int'(pattern_mem[4*num_tests+1][4:0]) + 1)) + 64;
            num_tests++;
        end
        timeout_limit += RESET_CYCLES + 4;
        if (num_tests == 0 || num_tests == MAX_TESTS) begin
            errors++;
            $display("Pattern file is empty or has no end marker");
        end

        err_before = errors;
        repeat (RESET_CYCLES) begin
            @(posedge clk);
            #1;
            check_pair("bcd_led", '0, bcd_led);         // Held by async reset
            check_display(dark, display);
        end
        rst_n = 1'b1;
        @(negedge clk);
        check_pair("bcd_led", '0, bcd_led);             // Nothing clocked since release
        check_display(dark, display);
        prev_pair = bcd_led;
        if (errors == err_before) begin
            pass_count++;
            $display("Test 0 reset state: pass");
        end else begin
            fail_count++;
            $display("Test 0 reset state: fail");
        end

        for (int t = 0; t < num_tests; t++) begin
            run_line(t);
        end

        $display("Tests passed %0d, failed %0d, errors %0d", pass_count, fail_count, errors);
        if (errors == 0 && fail_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* dv/count_patterns.txt */
// Columns in hex: dir (1 is down), sw, step count, expected tens and units after the steps
// Lines run in order and the count carries over from one line to the next
00 00 0c 12
00 01 05 17
01 01 08 09
01 00 0c 97
00 02 06 03
00 03 04 07
01 03 09 98
01 02 05 93
00 00 07 00
01 00 03 97
01 01 58 09
00 02 04 13
00 00 5f 08
01 03 03 05
00 01 0a 15
01 02 10 99
00 00 01 00
ff ff ff ff // End marker

/* list.f */
design/counter_pkg.sv
design/tick_gen.sv
design/bcd_digit.sv
design/seg_scan.sv
design/bcd_display_top.sv
dv/tb_bcd_display.sv

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator and run it from the project root
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
    --top-module tb_bcd_display \
    -f list.f \
    -o sim_bcd_display

out=$(./obj_dir/sim_bcd_display)
echo "$out"

if echo "$out" | grep -qx "ALL TESTS PASSED"; then
    exit 0
fi
exit 1
